/* build.f */
logic/ExAddrPkg.sv
logic/ExOpPkg.sv
logic/ExIssueLatch.sv
logic/ExAGUC.sv
logic/ExMemReqOut.sv
logic/ExAguTop.sv
+incdir+test
test/ExAguTb.sv

/* logic/ExAGUC.sv */
// ----------------------------------------
// scaled-index address adder
// base + (index << scale), three carry-select
// chunks, upper chunk gated by 48-bit mode
// ----------------------------------------

`timescale 1ns/10ps

module ExAGUC (
	input  logic                             clock,
	input  logic [ExAddrPkg::addrWidth-1:0]  regValRm,
	input  logic [ExAddrPkg::addrWidth-1:0]  regValRi,
	input  logic [ExOpPkg::ixtWidth-1:0]     idUIxt,
	input  logic                             addrEnJq,
	output logic [ExAddrPkg::addrWidth-1:0]  regOutAddr
);

	import ExAddrPkg::*;
	import ExOpPkg::*;

	// index after the scale shift
	logic [addrWidth-1:0]  riScaled;
	// scale field of the extension word
	logic [1:0]            scale;

	// lower chunk, carry out in the top bit
	logic [chunkWidth:0]   sumLow;
	// middle chunk for carry-in 0 and 1
	logic [chunkWidth:0]   sumMid0;
	logic [chunkWidth:0]   sumMid1;
	// upper chunk for carry-in 0 and 1, no carry out kept
	logic [chunkWidth-1:0] sumHigh0;
	logic [chunkWidth-1:0] sumHigh1;
	// selected middle, its carry picks the upper
	logic [chunkWidth:0]   sumMid;
	logic [chunkWidth-1:0] sumHigh;

	assign scale = idUIxt[ixtScaleHi:ixtScaleLo];

	always_comb
	begin
		// shift by 0..3, bits above the top fall off
		unique case (scale)
			scaleByte: riScaled = regValRi;
			scaleWord: riScaled = {regValRi[addrWidth-2:0], 1'b0};
			scaleLong: riScaled = {regValRi[addrWidth-3:0], 2'b0};
			scaleQuad: riScaled = {regValRi[addrWidth-4:0], 3'b0};
			default:   riScaled = regValRi;
		endcase

		// chunk sums, zero-extended by one bit for the carry
		sumLow   = {1'b0, regValRm[chunkWidth-1:0]}
			+ {1'b0, riScaled[chunkWidth-1:0]};
		sumMid0  = {1'b0, regValRm[2*chunkWidth-1:chunkWidth]}
			+ {1'b0, riScaled[2*chunkWidth-1:chunkWidth]};
		sumMid1  = {1'b0, regValRm[2*chunkWidth-1:chunkWidth]}
			+ {1'b0, riScaled[2*chunkWidth-1:chunkWidth]} + 1'b1;
		// top chunk, its carry out falls off
		sumHigh0 = regValRm[3*chunkWidth-1:2*chunkWidth]
			+ riScaled[3*chunkWidth-1:2*chunkWidth];
		sumHigh1 = regValRm[3*chunkWidth-1:2*chunkWidth]
			+ riScaled[3*chunkWidth-1:2*chunkWidth] + 1'b1;

		// carry from the lower chunk picks the middle
		sumMid = sumLow[chunkWidth] ? sumMid1 : sumMid0;

		// 32-bit mode keeps the upper chunk at zero
		sumHigh = '0;
		if (addrEnJq)
		begin
			// final carry out of the upper chunk is dropped
			sumHigh = sumMid[chunkWidth] ? sumHigh1 : sumHigh0;
		end

		regOutAddr = {sumHigh, sumMid[chunkWidth-1:0], sumLow[chunkWidth-1:0]};
	end

	// carry-select result against a plain add, upper chunk zero in 32-bit mode
	addrMatchesSum: assert property (
		@(posedge clock)
		regOutAddr == (addrEnJq ? (regValRm + riScaled)
			: {{chunkWidth{1'b0}}, regValRm[2*chunkWidth-1:0] + riScaled[2*chunkWidth-1:0]})
	) else $error("address differs from base plus scaled index");

endmodule

/* logic/ExAddrPkg.sv */
// ----------------------------------------
// address-side constants for the AGU slice
// widths, carry-select chunk size, scale codes
// ----------------------------------------

package ExAddrPkg;

	// full address and register width
	localparam int addrWidth = 48;

	// one carry-select chunk, three of them span the address
	localparam int chunkWidth = 16;

	// scale codes, value is the index shift in bits
	localparam logic [1:0] scaleByte = 2'd0;
	// index shifted by one
	localparam logic [1:0] scaleWord = 2'd1;
	// index shifted by two
	localparam logic [1:0] scaleLong = 2'd2;
	// index shifted by three
	localparam logic [1:0] scaleQuad = 2'd3;

endpackage

/* logic/ExAguTop.sv */
// ----------------------------------------
// AGU slice top level
// input latch, address adder, request stage
// ----------------------------------------

`timescale 1ns/10ps

module ExAguTop (
	input  logic                                          clock,
	input  logic                                          rstN,
	input  logic                                          opStrobe,
	input  logic [ExAddrPkg::addrWidth-1:0]               regValRm,
	input  logic [ExAddrPkg::addrWidth-1:0]               regValRi,
	input  logic [ExOpPkg::ixtWidth-1:0]                  idUIxt,
	input  logic                                          srT,
	input  logic                                          addrEnJq,
	output logic                                          memReqValid,
	output logic [ExAddrPkg::addrWidth-1:0]               memReqAddr,
	output logic [ExOpPkg::ixtTypeHi-ExOpPkg::ixtTypeLo:0] memReqType,
	output logic                                          memReqZx,
	output logic                                          misalignFault
);

	import ExAddrPkg::*;
	import ExOpPkg::*;

	// latched operands
	logic [addrWidth-1:0] latRm;
	logic [addrWidth-1:0] latRi;
	logic [ixtWidth-1:0]  latIxt;
	logic                 latEnJq;
	// predicate passed, op moves on
	logic                 latGo;
	// combinational effective address
	logic [addrWidth-1:0] aguAddr;

	ExIssueLatch i_ExIssueLatch (
		.clock    (clock),
		.rstN     (rstN),
		.opStrobe (opStrobe),
		.regValRm (regValRm),
		.regValRi (regValRi),
		.idUIxt   (idUIxt),
		.srT      (srT),
		.addrEnJq (addrEnJq),
		.latRm    (latRm),
		.latRi    (latRi),
		.latIxt   (latIxt),
		.latEnJq  (latEnJq),
		.latGo    (latGo)
	);

	// clock only feeds the adder's check
	ExAGUC i_ExAGUC (
		.clock      (clock),
		.regValRm   (latRm),
		.regValRi   (latRi),
		.idUIxt     (latIxt),
		.addrEnJq   (latEnJq),
		.regOutAddr (aguAddr)
	);

	ExMemReqOut i_ExMemReqOut (
		.clock         (clock),
		.rstN          (rstN),
		.aguAddr       (aguAddr),
		.latIxt        (latIxt),
		.latGo         (latGo),
		.memReqValid   (memReqValid),
		.memReqAddr    (memReqAddr),
		.memReqType    (memReqType),
		.memReqZx      (memReqZx),
		.misalignFault (misalignFault)
	);

endmodule

/* logic/ExIssueLatch.sv */
// ----------------------------------------
// AGU input stage
// operand latch on strobe, predicate decode
// ----------------------------------------

`timescale 1ns/10ps

module ExIssueLatch (
	input  logic                             clock,
	input  logic                             rstN,
	input  logic                             opStrobe,
	input  logic [ExAddrPkg::addrWidth-1:0]  regValRm,
	input  logic [ExAddrPkg::addrWidth-1:0]  regValRi,
	input  logic [ExOpPkg::ixtWidth-1:0]     idUIxt,
	input  logic                             srT,
	input  logic                             addrEnJq,
	output logic [ExAddrPkg::addrWidth-1:0]  latRm,
	output logic [ExAddrPkg::addrWidth-1:0]  latRi,
	output logic [ExOpPkg::ixtWidth-1:0]     latIxt,
	output logic                             latEnJq,
	output logic                             latGo
);

	import ExAddrPkg::*;
	import ExOpPkg::*;

	// cc field of the incoming op
	logic [1:0] condCode;
	// predicate result for this op
	logic       predPass;

	assign condCode = idUIxt[ixtCcHi:ixtCcLo];

	// AL/NV/CT/CF against the T flag
	always_comb
	begin
		unique case (condCode)
			ccAlways: predPass = 1'b1;
			ccNever:  predPass = 1'b0;
			ccTrue:   predPass = srT;
			ccFalse:  predPass = ~srT;
			default:  predPass = 1'b0;
		endcase
	end

	// operand capture, only when an op arrives
	always_ff @(posedge clock)
	begin
		if (opStrobe)
		begin
			latRm   <= regValRm;
			latRi   <= regValRi;
			latIxt  <= idUIxt;
			latEnJq <= addrEnJq;
		end
	end

	// go pulse, one per strobed op that passes
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			latGo <= 1'b0;
		end
		else
		begin
			latGo <= opStrobe & predPass;
		end
	end

	// every go cycle traces back to a strobe one edge earlier
	goNeedsStrobe: assert property (
		@(posedge clock) disable iff (!rstN)
		latGo |-> $past(opStrobe)
	) else $error("latGo without a strobed op");

endmodule

/* logic/ExMemReqOut.sv */
// ----------------------------------------
// AGU output stage
// address register, alignment check,
// request or fault pulse
// ----------------------------------------

`timescale 1ns/10ps

module ExMemReqOut (
	input  logic                                          clock,
	input  logic                                          rstN,
	input  logic [ExAddrPkg::addrWidth-1:0]               aguAddr,
	input  logic [ExOpPkg::ixtWidth-1:0]                  latIxt,
	input  logic                                          latGo,
	output logic                                          memReqValid,
	output logic [ExAddrPkg::addrWidth-1:0]               memReqAddr,
	output logic [ExOpPkg::ixtTypeHi-ExOpPkg::ixtTypeLo:0] memReqType,
	output logic                                          memReqZx,
	output logic                                          misalignFault
);

	import ExAddrPkg::*;
	import ExOpPkg::*;

	// access size code of the op in flight
	logic [ixtTypeHi-ixtTypeLo:0] accType;
	// address fits the access size
	logic                         isAligned;

	assign accType = latIxt[ixtTypeHi:ixtTypeLo];

	// low address bits must be clear per size
	always_comb
	begin
		unique case (accType)
			typeByte: isAligned = 1'b1;
			typeWord: isAligned = (aguAddr[0] == 1'b0);
			typeLong: isAligned = (aguAddr[1:0] == 2'b00);
			typeQuad: isAligned = (aguAddr[2:0] == 3'b000);
			default:  isAligned = 1'b0;
		endcase
	end

	// request payload, held until the next go
	always_ff @(posedge clock)
	begin
		if (latGo)
		begin
			memReqAddr <= aguAddr;
			memReqType <= accType;
			// only carried along, load extension is elsewhere
			memReqZx   <= latIxt[ixtZxBit];
		end
	end

	// result pulses, one cycle after go
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			memReqValid   <= 1'b0;
			misalignFault <= 1'b0;
		end
		else
		begin
			memReqValid   <= latGo & isAligned;
			misalignFault <= latGo & ~isAligned;
		end
	end

	// request and fault are exclusive
	reqFaultExcl: assert property (
		@(posedge clock) disable iff (!rstN)
		!(memReqValid && misalignFault)
	) else $error("request and fault in the same cycle");

	// each pulse cycle belongs to exactly one go from the stage before
	pulsePerGo: assert property (
		@(posedge clock) disable iff (!rstN)
		(memReqValid || misalignFault) |-> $past(latGo)
	) else $error("result pulse without a go");

endmodule

/* logic/ExOpPkg.sv */
// ----------------------------------------
// operation-side constants for the AGU slice
// extension word layout, condition codes,
// access type codes
// ----------------------------------------

package ExOpPkg;

	// extension word from the decoder
	localparam int ixtWidth = 8;

	// condition code field
	localparam int ixtCcHi = 7;
	localparam int ixtCcLo = 6;

	// access type field, sets the access size
	localparam int ixtTypeHi = 5;
	localparam int ixtTypeLo = 4;

	// bit 3 is reserved, nothing decodes it

	// zero-extend flag, 0 means sign extend
	localparam int ixtZxBit = 2;

	// index scale field
	localparam int ixtScaleHi = 1;
	localparam int ixtScaleLo = 0;

	// condition codes
	// always execute
	localparam logic [1:0] ccAlways = 2'd0;
	// never execute
	localparam logic [1:0] ccNever = 2'd1;
	// execute if T flag set
	localparam logic [1:0] ccTrue = 2'd2;
	// execute if T flag clear
	localparam logic [1:0] ccFalse = 2'd3;

	// access types, size in bytes is 1 << code
	localparam logic [1:0] typeByte = 2'd0;
	localparam logic [1:0] typeWord = 2'd1;
	localparam logic [1:0] typeLong = 2'd2;
	localparam logic [1:0] typeQuad = 2'd3;

endpackage

/* run.sh */
#!/bin/sh
# build and run the AGU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module ExAguTb -o simExAgu

# the log decides the result, not the exit status
./obj_dir/simExAgu > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "run.sh: simulation reported a failure"
	exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "run.sh: simulation ended without a result"
	exit 1
fi

echo "run.sh: simulation ok"

/* test/ExAguModel.svh */
// ----------------------------------------
// reference model for the AGU testbench
// predicate, effective address, alignment
// ----------------------------------------

`ifndef EX_AGU_MODEL_SVH
`define EX_AGU_MODEL_SVH

// does the op execute under its condition code
function automatic logic modelPredicate(input logic [1:0] cc, input logic tFlag);
	logic pass;
	pass = 1'b0;
	case (cc)
		ccAlways: pass = 1'b1;
		ccNever:  pass = 1'b0;
		// CT needs T set, CF needs it clear
		ccTrue:   pass = (tFlag == 1'b1);
		ccFalse:  pass = (tFlag == 1'b0);
		default:  pass = 1'b0;
	endcase
	return pass;
endfunction

// plain wide sum, then truncated to the active address size
function automatic logic [addrWidth-1:0] modelAddress(
	input logic [addrWidth-1:0] base,
	input logic [addrWidth-1:0] index,
	input logic [1:0]           scale,
	input logic                 wide48
);
	logic [addrWidth+3:0] full;
	logic [addrWidth-1:0] addr;
	full = {4'b0, base} + ({4'b0, index} << scale);
	addr = full[addrWidth-1:0];
	// 32-bit mode, upper 16 bits forced to zero
	if (!wide48)
		addr[addrWidth-1:32] = '0;
	return addr;
endfunction

// address must be a multiple of the access size
function automatic logic modelAligned(input logic [addrWidth-1:0] addr, input logic [1:0] accType);
	logic [3:0] sizeBytes;
	sizeBytes = 4'd1 << accType;
	return (({1'b0, addr[2:0]} % sizeBytes) == 4'd0);
endfunction

`endif

/* test/ExAguTb.sv */
// ----------------------------------------
// testbench for the AGU slice top level
// clock, reset, random and directed ops,
// scoreboard queue, compare tasks, watchdog
// ----------------------------------------

`timescale 1ns/10ps

module ExAguTb;

	import ExAddrPkg::*;
	import ExOpPkg::*;

	localparam int resetCycles = 16;
	localparam int numDirected = 12;
	localparam int numRandom   = 2000;
	localparam int drainCycles = 4;
	localparam int numOps      = numDirected + numRandom + drainCycles;
	// four clock periods per op, plus reset
	localparam int timeoutNs   = numOps * 8 * 4 + resetCycles * 8;

	logic                         clock;
	logic                         rstN;
	logic                         opStrobe;
	logic [addrWidth-1:0]         regValRm;
	logic [addrWidth-1:0]         regValRi;
	logic [ixtWidth-1:0]          idUIxt;
	logic                         srT;
	logic                         addrEnJq;
	logic                         memReqValid;
	logic [addrWidth-1:0]         memReqAddr;
	logic [ixtTypeHi-ixtTypeLo:0] memReqType;
	logic                         memReqZx;
	logic                         misalignFault;

	// falling edges seen so far
	int cyc;
	// expected results, tagged with the cycle they are due
	int                           dueQ[$];
	logic                         faultQ[$];
	logic [addrWidth-1:0]         addrQ[$];
	logic [ixtTypeHi-ixtTypeLo:0] typeQ[$];
	logic                         zxQ[$];

	`include "ExAguModel.svh"

	ExAguTop i_ExAguTop (
		.clock         (clock),
		.rstN          (rstN),
		.opStrobe      (opStrobe),
		.regValRm      (regValRm),
		.regValRi      (regValRi),
		.idUIxt        (idUIxt),
		.srT           (srT),
		.addrEnJq      (addrEnJq),
		.memReqValid   (memReqValid),
		.memReqAddr    (memReqAddr),
		.memReqType    (memReqType),
		.memReqZx      (memReqZx),
		.misalignFault (misalignFault)
	);

	always #4 clock = ~clock;

	task automatic checkAddr(input string sigName, input logic [addrWidth-1:0] expVal,
		input logic [addrWidth-1:0] actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL time=%0t %s expected=%h actual=%h", $time, sigName, expVal, actVal);
			$display("TESTBENCH FAILED");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic checkType(input string sigName, input logic [ixtTypeHi-ixtTypeLo:0] expVal,
		input logic [ixtTypeHi-ixtTypeLo:0] actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL time=%0t %s expected=%h actual=%h", $time, sigName, expVal, actVal);
			$display("TESTBENCH FAILED");
			$fatal(1, "type mismatch");
		end
	endtask

	task automatic checkBit(input string sigName, input logic expVal, input logic actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL time=%0t %s expected=%b actual=%b", $time, sigName, expVal, actVal);
			$display("TESTBENCH FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// outputs are stable at the falling edge
	task automatic checkOutputs();
		logic                         expFault;
		logic [addrWidth-1:0]         expAddr;
		logic [ixtTypeHi-ixtTypeLo:0] expType;
		logic                         expZx;
		if (dueQ.size() > 0 && dueQ[0] == cyc)
		begin
			void'(dueQ.pop_front());
			expFault = faultQ.pop_front();
			expAddr  = addrQ.pop_front();
			expType  = typeQ.pop_front();
			expZx    = zxQ.pop_front();
			checkBit("memReqValid", !expFault, memReqValid);
			checkBit("misalignFault", expFault, misalignFault);
			// payload only matters for a real request
			if (!expFault)
			begin
				checkAddr("memReqAddr", expAddr, memReqAddr);
				checkType("memReqType", expType, memReqType);
				checkBit("memReqZx", expZx, memReqZx);
			end
		end
		else
		begin
			// nothing due, so no pulse at all
			checkBit("memReqValid", 1'b0, memReqValid);
			checkBit("misalignFault", 1'b0, misalignFault);
		end
	endtask

	task automatic nextCycle();
		@(negedge clock);
		cyc++;
		checkOutputs();
	endtask

	function automatic logic [addrWidth-1:0] randWide();
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return r[addrWidth-1:0];
	endfunction

	// strobe one op, queue its result if the predicate passes
	task automatic runOp(input logic [addrWidth-1:0] rm, input logic [addrWidth-1:0] ri,
		input logic [ixtWidth-1:0] ixt, input logic tFlag, input logic en48);
		logic [addrWidth-1:0] addr;
		nextCycle();
		opStrobe = 1'b1;
		regValRm = rm;
		regValRi = ri;
		idUIxt   = ixt;
		srT      = tFlag;
		addrEnJq = en48;
		if (modelPredicate(ixt[ixtCcHi:ixtCcLo], tFlag))
		begin
			addr = modelAddress(rm, ri, ixt[ixtScaleHi:ixtScaleLo], en48);
			// sampled next rising edge, result two edges later
			dueQ.push_back(cyc + 2);
			faultQ.push_back(!modelAligned(addr, ixt[ixtTypeHi:ixtTypeLo]));
			addrQ.push_back(addr);
			typeQ.push_back(ixt[ixtTypeHi:ixtTypeLo]);
			zxQ.push_back(ixt[ixtZxBit]);
		end
	endtask

	// no strobe, junk on the data inputs
	task automatic runIdle();
		logic [31:0] r;
		nextCycle();
		r        = $urandom();
		opStrobe = 1'b0;
		regValRm = randWide();
		regValRi = randWide();
		idUIxt   = r[7:0];
		srT      = r[8];
		addrEnJq = r[9];
	endtask

	// watchdog
	initial
	begin
		#(timeoutNs);
		$display("watchdog expired before the test sequence completed");
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		logic [31:0]          r;
		logic [addrWidth-1:0] rm;
		logic [addrWidth-1:0] ri;
		r        = $urandom(32'hd3d9);
		cyc      = 0;
		clock    = 1'b0;
		rstN     = 1'b0;
		opStrobe = 1'b0;
		regValRm = '0;
		regValRi = '0;
		idUIxt   = '0;
		srT      = 1'b0;
		addrEnJq = 1'b0;
		repeat (resetCycles) nextCycle();
		rstN = 1'b1;

		// carry out of the low chunk
		runOp(48'h0000_0000_FFFF, 48'h1, {ccAlways, typeByte, 1'b0, 1'b0, scaleByte}, 1'b0, 1'b1);
		// carry through both boundaries
		runOp(48'h0000_FFFF_FFFF, 48'h1, {ccAlways, typeByte, 1'b0, 1'b1, scaleByte}, 1'b0, 1'b1);
		// same in 32-bit mode wraps to zero
		runOp(48'h0000_FFFF_FFFF, 48'h1, {ccAlways, typeByte, 1'b0, 1'b0, scaleByte}, 1'b0, 1'b0);
		// final carry dropped
		runOp(48'hFFFF_FFFF_FFFF, 48'h1, {ccAlways, typeWord, 1'b0, 1'b1, scaleByte}, 1'b1, 1'b1);
		runOp(48'h0000_0000_FFF8, 48'h1, {ccAlways, typeQuad, 1'b0, 1'b0, scaleQuad}, 1'b0, 1'b1);
		// scaled index carries mid into upper
		runOp(48'h0000_FFFF_0000, 48'h2000, {ccTrue, typeLong, 1'b0, 1'b1, scaleQuad}, 1'b1, 1'b1);
		// index bits shifted off the top
		runOp(48'h10, 48'hF000_0000_0001, {ccFalse, typeLong, 1'b1, 1'b0, scaleQuad}, 1'b0, 1'b1);
		// misaligned word and long
		runOp(48'h1, 48'h0, {ccAlways, typeWord, 1'b0, 1'b0, scaleByte}, 1'b0, 1'b1);
		runOp(48'h1, 48'h1, {ccAlways, typeLong, 1'b0, 1'b0, scaleWord}, 1'b0, 1'b0);
		// predicate failures, no result expected
		runOp(48'h40, 48'h4, {ccNever, typeByte, 1'b0, 1'b0, scaleByte}, 1'b1, 1'b1);
		runOp(48'h40, 48'h4, {ccTrue, typeByte, 1'b0, 1'b0, scaleByte}, 1'b0, 1'b1);
		runOp(48'h40, 48'h4, {ccFalse, typeByte, 1'b0, 1'b0, scaleByte}, 1'b1, 1'b1);

		// mostly strobes, so bursts are frequent
		for (int i = 0; i < numRandom; i++)
		begin
			r  = $urandom();
			rm = randWide();
			ri = randWide();
			// clear low bits half the time to get aligned quads
			if (r[12])
				rm[2:0] = 3'b000;
			if (r[13])
				ri[2:0] = 3'b000;
			if (r[3:0] < 4'd12)
				runOp(rm, ri, r[23:16], r[24], r[25]);
			else
				runIdle();
		end

		repeat (drainCycles) runIdle();

		if (dueQ.size() != 0)
		begin
			$display("expected results never appeared at the outputs");
			$display("TESTBENCH FAILED");
			$fatal(1, "results lost");
		end
		else
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule
